/* design/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data and virtual address width
`define XLEN 32

// physical address width for sv32
`define PA_BITS 34

// full physical page number, also the root table base
`define PPN_BITS 22

// dtlb size, fully associative
`define TLB_ENTRIES 4

`endif

/* design/lsuPkg.sv */
`default_nettype none

`include "lsu_defines.svh"

package lsuPkg;

  ////////////////////////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////////////////////////

  typedef logic [`XLEN-1:0] wordT;
  typedef logic [`XLEN-1:0] vAdrT;
  typedef logic [`PA_BITS-1:0] pAdrT;
  typedef logic [`PPN_BITS-1:0] ppnT;
  // megapage fields of sv32
  typedef logic [9:0] vpn1T;
  typedef logic [11:0] ppn1T;
  // one enable bit per byte lane
  typedef logic [3:0] strobeT;
  // riscv load/store size and sign encoding
  typedef logic [2:0] funct3T;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    memNone, memLoad, memStore, memLoadRes, memStoreCond
  } memOpT;

  typedef enum logic [2:0] {
    faultNone, faultLoadMisaligned, faultStoreMisaligned, faultLoadPage, faultStorePage
  } faultT;

  // interlock fsm of the lsu
  typedef enum logic [2:0] {
    lsuIdle, lsuLookup, lsuWalk, lsuBusReq, lsuBusWait, lsuRespond
  } lsuStateT;

  // page walker fsm
  typedef enum logic [1:0] {
    walkIdle, walkReq, walkWait
  } walkStateT;

endpackage

`default_nettype wire

/* design/walkMemIf.sv */
`timescale 1ns/100ps
`default_nettype none

// read-only memory port of the page walker, served by the lsu bus arbiter
interface walkMemIf;
  import lsuPkg::*;

  // request side, held while reqValid and not reqReady
  logic reqValid;
  logic reqReady;
  pAdrT adr;
  // one-cycle response pulse
  logic respValid;
  wordT rdata;

  modport walker (
    output reqValid,
    output adr,
    input  reqReady,
    input  respValid,
    input  rdata
  );

  modport arbiter (
    input  reqValid,
    input  adr,
    output reqReady,
    output respValid,
    output rdata
  );

endinterface

`default_nettype wire

/* design/dataTlb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module dataTlb (
  input  logic         clk,
  input  logic         reset,
  input  logic         flush,
  input  lsuPkg::vpn1T vpn1,
  output logic         hit,
  output lsuPkg::ppn1T ppn1,
  output logic         readOk,
  output logic         writeOk,
  input  logic         fill,
  input  lsuPkg::vpn1T fillVpn1,
  input  lsuPkg::ppn1T fillPpn1,
  input  logic         fillRead,
  input  logic         fillWrite
);
  import lsuPkg::*;

  localparam int IdxBits = $clog2(`TLB_ENTRIES);

  logic [`TLB_ENTRIES-1:0] validQ;
  logic [`TLB_ENTRIES-1:0] readQ;
  logic [`TLB_ENTRIES-1:0] writeQ;
  logic [`TLB_ENTRIES-1:0] hitVec;
  vpn1T tagQ [`TLB_ENTRIES];
  ppn1T ppnQ [`TLB_ENTRIES];
  // round-robin victim
  logic [IdxBits-1:0] victimQ;
  logic [IdxBits-1:0] victimNext;

  assign victimNext = (victimQ == IdxBits'(`TLB_ENTRIES - 1)) ? '0 : victimQ + 1'b1;

  // parallel tag compare, hit entry fields or-ed together
  always_comb begin
    ppn1 = '0;
    readOk = 1'b0;
    writeOk = 1'b0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      hitVec[i] = validQ[i] && (tagQ[i] == vpn1);
      if (hitVec[i]) begin
        ppn1 = ppn1 | ppnQ[i];
        readOk = readOk | readQ[i];
        writeOk = writeOk | writeQ[i];
      end
    end
  end

  assign hit = |hitVec;

  // valid bits and pointer, flush wins over a refill
  always_ff @(posedge clk) begin
    if (reset) begin
      validQ <= '0;
      victimQ <= '0;
    end else if (flush) begin
      validQ <= '0;
    end else if (fill) begin
      validQ[victimQ] <= 1'b1;
      victimQ <= victimNext;
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (fill) begin
      tagQ[victimQ] <= fillVpn1;
      ppnQ[victimQ] <= fillPpn1;
      readQ[victimQ] <= fillRead;
      writeQ[victimQ] <= fillWrite;
    end
  end

  // refills only follow a miss, so tags never repeat
  tlbSingleHit: assert property (@(posedge clk) disable iff (reset) $onehot0(hitVec));

endmodule

`default_nettype wire

/* design/pageWalker.sv */
`timescale 1ns/100ps
`default_nettype none

module pageWalker (
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  lsuPkg::ppnT  ptBase,
  input  lsuPkg::vpn1T vpn1,
  input  logic         isStore,
  walkMemIf.walker     mem,
  output logic         done,
  output logic         fault,
  output lsuPkg::ppn1T leafPpn1,
  output logic         leafRead,
  output logic         leafWrite
);
  import lsuPkg::*;

  walkStateT state, nextState;
  pAdrT pteAdrQ;
  wordT pte;
  logic pteValid, pteR, pteW, pteX;
  logic pteBad;
  logic pteArrived;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      walkIdle: if (start) nextState = walkReq;
      walkReq:  if (mem.reqReady) nextState = walkWait;
      walkWait: if (mem.respValid) nextState = walkIdle;
      default:  nextState = walkIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= walkIdle;
    else state <= nextState;
  end

  // level-1 pte lives at ptBase*4096 + vpn1*4
  always_ff @(posedge clk) begin
    if (state == walkIdle && start) pteAdrQ <= {ptBase, vpn1, 2'b00};
  end

  // single read, address stays put until accepted
  assign mem.reqValid = (state == walkReq);
  assign mem.adr = pteAdrQ;

  ////////////////////////////////////////////////////////////
  // pte checks
  ////////////////////////////////////////////////////////////

  assign pte = mem.rdata;
  assign pteValid = pte[0];
  assign pteR = pte[1];
  assign pteW = pte[2];
  assign pteX = pte[3];

  // invalid, pointer to next level, reserved w-only, or missing permission
  assign pteBad = !pteValid
                || !(pteR || pteX)
                || (pteW && !pteR)
                || (isStore ? !pteW : !pteR);

  assign pteArrived = (state == walkWait) && mem.respValid;
  assign done = pteArrived && !pteBad;
  assign fault = pteArrived && pteBad;

  // leaf fields, valid with the done pulse
  assign leafPpn1 = pte[31:20];
  assign leafRead = pteR;
  assign leafWrite = pteW;

endmodule

`default_nettype wire

/* design/reservationSet.sv */
`timescale 1ns/100ps
`default_nettype none

module reservationSet (
  input  logic          clk,
  input  logic          reset,
  input  logic          commit,
  input  lsuPkg::memOpT op,
  input  lsuPkg::pAdrT  pAdr,
  output logic          scSuccess
);
  import lsuPkg::*;

  localparam int PaBits = $bits(pAdrT);

  logic resValidQ;
  pAdrT resAdrQ;
  logic sameWord;

  // reservation granule is one word
  assign sameWord = resAdrQ[PaBits-1:2] == pAdr[PaBits-1:2];
  assign scSuccess = resValidQ && sameWord;

  always_ff @(posedge clk) begin
    if (reset) begin
      resValidQ <= 1'b0;
    end else if (commit) begin
      case (op)
        memLoadRes:   resValidQ <= 1'b1;
        // sc consumes it whether or not it succeeded
        memStoreCond: resValidQ <= 1'b0;
        memStore:     if (sameWord) resValidQ <= 1'b0;
        default:      resValidQ <= resValidQ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (commit && op == memLoadRes) resAdrQ <= pAdr;
  end

endmodule

`default_nettype wire

/* design/subwordUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module subwordUnit (
  input  lsuPkg::funct3T funct3,
  input  logic [1:0]     adrLow,
  input  lsuPkg::wordT   storeData,
  input  lsuPkg::wordT   rawLoad,
  output logic           misaligned,
  output lsuPkg::wordT   busData,
  output lsuPkg::strobeT strobe,
  output lsuPkg::wordT   loadData
);
  import lsuPkg::*;

  wordT shifted;

  // funct3[1:0] gives the size, funct3[2] selects zero extension
  always_comb begin
    case (funct3[1:0])
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = adrLow[0];
      default: misaligned = |adrLow;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // store lanes
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        busData = {4{storeData[7:0]}};
        strobe = strobeT'(4'b0001 << adrLow);
      end
      2'b01: begin
        busData = {2{storeData[15:0]}};
        strobe = adrLow[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        busData = storeData;
        strobe = 4'b1111;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // load extraction
  ////////////////////////////////////////////////////////////

  // addressed byte moves down to lane 0
  assign shifted = rawLoad >> {adrLow, 3'b000};

  always_comb begin
    case (funct3[1:0])
      2'b00:   loadData = funct3[2] ? {24'b0, shifted[7:0]}
                                    : {{24{shifted[7]}}, shifted[7:0]};
      2'b01:   loadData = funct3[2] ? {16'b0, shifted[15:0]}
                                    : {{16{shifted[15]}}, shifted[15:0]};
      default: loadData = shifted;
    endcase
  end

endmodule

`default_nettype wire

/* design/lsu.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu (
  input  logic           clk,
  input  logic           reset,
  input  logic           reqValid,
  output logic           reqReady,
  input  lsuPkg::memOpT  reqOp,
  input  lsuPkg::funct3T reqFunct3,
  input  lsuPkg::vAdrT   reqAdr,
  input  lsuPkg::wordT   reqWdata,
  output logic           respValid,
  input  logic           respReady,
  output lsuPkg::wordT   respData,
  output lsuPkg::faultT  respFault,
  input  logic           transEn,
  input  lsuPkg::ppnT    ptBase,
  input  logic           tlbFlush,
  output logic           busValid,
  input  logic           busReady,
  output lsuPkg::pAdrT   busAdr,
  output logic           busWrite,
  output lsuPkg::wordT   busWdata,
  output lsuPkg::strobeT busStrobe,
  input  logic           busRespValid,
  input  lsuPkg::wordT   busRdata
);
  import lsuPkg::*;

  lsuStateT state, nextState;
  // request register
  memOpT opQ;
  funct3T funct3Q;
  vAdrT adrQ;
  wordT wdataQ;
  logic storeClass;
  // translation
  logic tlbHit, tlbReadOk, tlbWriteOk;
  ppn1T tlbPpn1;
  pAdrT pAdrComb, pAdrQ, resAdr;
  logic permFault, misaligned;
  faultT lookupFault;
  // walker
  logic walkStart, walkDone, walkFault, leafRead, leafWrite, selWalk;
  ppn1T leafPpn1;
  // lr/sc and datapath
  logic scSuccess, scFail, commit, respLoad;
  wordT loadData, storeLanes, respDataQ, respDataNext;
  strobeT storeStrobe;
  faultT respFaultQ, respFaultNext;

  walkMemIf walkMem();

  always_ff @(posedge clk) begin
    if (reqValid && reqReady) begin
      opQ <= reqOp;
      funct3Q <= reqFunct3;
      adrQ <= reqAdr;
      wdataQ <= reqWdata;
    end
  end

  assign storeClass = (opQ == memStore) || (opQ == memStoreCond);

  // megapage keeps the low 22 address bits as offset
  assign pAdrComb = transEn ? {tlbPpn1, adrQ[21:0]} : pAdrT'(adrQ);
  assign permFault = transEn && tlbHit && (storeClass ? !tlbWriteOk : !tlbReadOk);
  assign scFail = (opQ == memStoreCond) && !scSuccess;

  always_comb begin
    if (misaligned) lookupFault = storeClass ? faultStoreMisaligned : faultLoadMisaligned;
    else if (permFault) lookupFault = storeClass ? faultStorePage : faultLoadPage;
    else lookupFault = faultNone;
  end

  ////////////////////////////////////////////////////////////
  // interlock / replay fsm
  ////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      lsuIdle: if (reqValid) nextState = lsuLookup;
      lsuLookup: begin
        if (lookupFault != faultNone) nextState = lsuRespond;
        else if (transEn && !tlbHit) nextState = lsuWalk;
        else if (scFail) nextState = lsuRespond;
        else nextState = lsuBusReq;
      end
      // refill replays the lookup
      lsuWalk: begin
        if (walkFault) nextState = lsuRespond;
        else if (walkDone) nextState = lsuLookup;
      end
      lsuBusReq:  if (busReady) nextState = lsuBusWait;
      lsuBusWait: if (busRespValid) nextState = lsuRespond;
      lsuRespond: if (respReady) nextState = lsuIdle;
      default:    nextState = lsuIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= lsuIdle;
    else state <= nextState;
  end

  assign walkStart = (state == lsuLookup) && (nextState == lsuWalk);

  // physical address frozen for the bus phase and reservation commit
  always_ff @(posedge clk) begin
    if (state == lsuLookup) pAdrQ <= pAdrComb;
  end
  assign resAdr = (state == lsuLookup) ? pAdrComb : pAdrQ;

  ////////////////////////////////////////////////////////////
  // bus arbiter, walker owns the bus only in walk
  ////////////////////////////////////////////////////////////

  assign selWalk = (state == lsuWalk);
  assign busValid = selWalk ? walkMem.reqValid : (state == lsuBusReq);
  assign busAdr = selWalk ? walkMem.adr : pAdrQ;
  assign busWrite = (state == lsuBusReq) && storeClass;
  assign busWdata = storeLanes;
  assign busStrobe = selWalk ? 4'b1111 : storeStrobe;
  assign walkMem.reqReady = selWalk && busReady;
  assign walkMem.respValid = selWalk && busRespValid;
  assign walkMem.rdata = busRdata;

  // response register
  assign respLoad = (nextState == lsuRespond) && (state != lsuRespond);

  always_comb begin
    case (state)
      lsuLookup: respFaultNext = lookupFault;
      lsuWalk:   respFaultNext = storeClass ? faultStorePage : faultLoadPage;
      default:   respFaultNext = faultNone;
    endcase
    if (state == lsuBusWait && !storeClass) respDataNext = loadData;
    else if (state == lsuLookup && lookupFault == faultNone && scFail) respDataNext = 32'd1;
    else respDataNext = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) respFaultQ <= faultNone;
    else if (respLoad) respFaultQ <= respFaultNext;
  end

  always_ff @(posedge clk) begin
    if (respLoad) respDataQ <= respDataNext;
  end

  assign reqReady = (state == lsuIdle);
  assign respValid = (state == lsuRespond);
  assign respData = respDataQ;
  assign respFault = respFaultQ;
  assign commit = respValid && respReady && (respFaultQ == faultNone);

  dataTlb dtlb (
    .clk, .reset, .flush(tlbFlush), .vpn1(adrQ[31:22]), .hit(tlbHit), .ppn1(tlbPpn1),
    .readOk(tlbReadOk), .writeOk(tlbWriteOk), .fill(walkDone), .fillVpn1(adrQ[31:22]),
    .fillPpn1(leafPpn1), .fillRead(leafRead), .fillWrite(leafWrite)
  );

  pageWalker walker (
    .clk, .reset, .start(walkStart), .ptBase, .vpn1(adrQ[31:22]), .isStore(storeClass),
    .mem(walkMem), .done(walkDone), .fault(walkFault), .leafPpn1, .leafRead, .leafWrite
  );

  reservationSet resSet (
    .clk, .reset, .commit, .op(opQ), .pAdr(resAdr), .scSuccess
  );

  subwordUnit subword (
    .funct3(funct3Q), .adrLow(adrQ[1:0]), .storeData(wdataQ), .rawLoad(busRdata),
    .misaligned, .busData(storeLanes), .strobe(storeStrobe), .loadData
  );

  // walker asks only while it owns the bus, and only reads
  walkBusOwner: assert property (@(posedge clk) disable iff (reset)
    walkMem.reqValid |-> (selWalk && busValid && !busWrite));

  // unaccepted response keeps its payload
  respHeld: assert property (@(posedge clk) disable iff (reset)
    (respValid && !respReady) |=> (respValid && $stable(respData) && $stable(respFault)));

  // faulted store never reaches the bus
  noFaultedWrite: assert property (@(posedge clk) disable iff (reset)
    (busValid && busWrite) |-> (lookupFault == faultNone));

endmodule

`default_nettype wire

/* sim/tbClock.sv */
`timescale 1ns/100ps
`default_nettype none

// free-running clock, 20 ns period
module tbClock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

`default_nettype wire

/* sim/tbMemory.sv */
`timescale 1ns/100ps
`default_nettype none

// bus slave with random ready and response latency
module tbMemory #(
  parameter logic [21:0] PtPage = 22'h0
) (
  input  logic           clk,
  input  logic           busValid,
  output logic           busReady,
  input  lsuPkg::pAdrT   busAdr,
  input  logic           busWrite,
  input  lsuPkg::wordT   busWdata,
  input  lsuPkg::strobeT busStrobe,
  output logic           busRespValid,
  output lsuPkg::wordT   busRdata,
  output int             ptReads
);
  import lsuPkg::*;

  // word storage, indexed by pa[23:22] and pa[11:2]
  wordT mem [4096];
  integer seed;
  int latency;
  logic [11:0] idx;
  wordT rdata;

  initial begin
    seed = 48;
    busReady = 1'b0;
    busRespValid = 1'b0;
    busRdata = '0;
    ptReads = 0;
  end

  always begin
    @(posedge clk);
    if (busValid && busReady) begin
      idx = {busAdr[23:22], busAdr[11:2]};
      rdata = mem[idx];
      if (busWrite) begin
        // only strobed lanes change
        for (int b = 0; b < 4; b++) begin
          if (busStrobe[b]) mem[idx][8*b +: 8] = busWdata[8*b +: 8];
        end
      end else if (busAdr[33:12] == PtPage) begin
        ptReads++;
      end
      #1;
      busReady = 1'b0;
      latency = {$random(seed)} % 4;
      repeat (latency) @(posedge clk);
      #1;
      busRespValid = 1'b1;
      busRdata = rdata;
      @(posedge clk);
      #1;
      busRespValid = 1'b0;
      busReady = ({$random(seed)} % 4) != 0;
    end else begin
      #1;
      // ready low about a quarter of the time
      busReady = ({$random(seed)} % 4) != 0;
    end
  end

endmodule

`default_nettype wire

/* sim/lsuTb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsuTb;
  import lsuPkg::*;

  localparam int MaxRows = 40;
  localparam int WaitLimit = 200;
  // root page table at physical 0x10000
  localparam ppnT PtBase = 22'h00010;
  localparam funct3T Byte = 3'b000;
  localparam funct3T Half = 3'b001;
  localparam funct3T Word = 3'b010;
  localparam funct3T ByteU = 3'b100;
  localparam funct3T HalfU = 3'b101;

  // one stimulus row with its expected response
  typedef struct packed {
    memOpT op;
    funct3T funct3;
    vAdrT adr;
    wordT wdata;
    logic trans;
    logic flush;
    wordT expData;
    faultT expFault;
    logic [1:0] walks;
  } rowT;

  logic clk, reset;
  logic reqValid, reqReady, respValid, respReady;
  logic transEn, tlbFlush;
  memOpT reqOp;
  funct3T reqFunct3;
  vAdrT reqAdr;
  wordT reqWdata, respData;
  faultT respFault;
  ppnT ptBase;
  logic busValid, busReady, busWrite, busRespValid;
  pAdrT busAdr;
  wordT busWdata, busRdata;
  strobeT busStrobe;
  int ptReads;

  rowT rows [MaxRows];
  // shadow copy of the bus memory
  wordT shadow [4096];
  int rowCount, errors, checks;
  integer seed;
  logic timedOut;

  tbClock clockGen (.clk);

  tbMemory #(.PtPage(PtBase)) busMem (
    .clk, .busValid, .busReady, .busAdr, .busWrite, .busWdata, .busStrobe,
    .busRespValid, .busRdata, .ptReads
  );

  lsu lsu_inst (
    .clk, .reset, .reqValid, .reqReady, .reqOp, .reqFunct3, .reqAdr, .reqWdata,
    .respValid, .respReady, .respData, .respFault, .transEn, .ptBase, .tlbFlush,
    .busValid, .busReady, .busAdr, .busWrite, .busWdata, .busStrobe, .busRespValid,
    .busRdata
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // same word folding as the bus memory
  function automatic logic [11:0] memIndex(pAdrT a);
    return {a[23:22], a[11:2]};
  endfunction

  // sv32 megapage, leaf ppn1 taken from the shadow page table
  function automatic pAdrT physAdr(vAdrT va, logic trans);
    wordT pte;
    pte = shadow[memIndex({PtBase, va[31:22], 2'b00})];
    return trans ? {pte[31:20], va[21:0]} : pAdrT'(va);
  endfunction

  function automatic wordT loadModel(wordT w, funct3T f3, logic [1:0] lo);
    logic [7:0] b;
    logic [15:0] h;
    b = w[8*lo +: 8];
    h = w[16*lo[1] +: 16];
    case (f3)
      Byte:    return {{24{b[7]}}, b};
      ByteU:   return {24'b0, b};
      Half:    return {{16{h[15]}}, h};
      HalfU:   return {16'b0, h};
      default: return w;
    endcase
  endfunction

  function automatic wordT storeModel(wordT old, wordT d, funct3T f3, logic [1:0] lo);
    wordT w;
    w = old;
    case (f3[1:0])
      2'b00:   w[8*lo +: 8] = d[7:0];
      2'b01:   w[16*lo[1] +: 16] = d[15:0];
      default: w = d;
    endcase
    return w;
  endfunction

  // one word into both the bus memory and the shadow
  task automatic setWord(input int idx, input wordT value);
    busMem.mem[idx] = value;
    shadow[idx] = value;
  endtask

  task automatic fillMemory();
    for (int i = 0; i < 4096; i++) begin
      setWord(i, 32'h9E37_79B9 * (i + 1));
    end
    // vpn1 1 rw, 2 read-only, 3 invalid, 4 pointer to a next level
    setWord(memIndex({PtBase, 10'd1, 2'b00}), 32'h0030_0007);
    setWord(memIndex({PtBase, 10'd2, 2'b00}), 32'h0040_0003);
    setWord(memIndex({PtBase, 10'd3, 2'b00}), 32'h0050_0006);
    setWord(memIndex({PtBase, 10'd4, 2'b00}), 32'h0000_4001);
  endtask

  task automatic addRow(memOpT op, funct3T f3, vAdrT adr, wordT wdata, logic trans,
                        logic flush, wordT data, faultT fault, logic [1:0] walks);
    rows[rowCount] = {op, f3, adr, wdata, trans, flush, data, fault, walks};
    rowCount++;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table, load data comes from the shadow
  ////////////////////////////////////////////////////////////

  task automatic buildTable();
    // physical addressing, lanes and extension
    addRow(memStore, Word, 32'h100, 32'h8123_4567, 0, 0, 0, faultNone, 0);
    addRow(memStore, Half, 32'h106, 32'h0000_F00D, 0, 0, 0, faultNone, 0);
    addRow(memStore, Byte, 32'h105, 32'h0000_0080, 0, 0, 0, faultNone, 0);
    addRow(memLoad, Word, 32'h100, 0, 0, 0, 0, faultNone, 0);
    addRow(memLoad, Byte, 32'h103, 0, 0, 0, 0, faultNone, 0);
    addRow(memLoad, ByteU, 32'h103, 0, 0, 0, 0, faultNone, 0);
    addRow(memLoad, Half, 32'h106, 0, 0, 0, 0, faultNone, 0);
    addRow(memLoad, HalfU, 32'h106, 0, 0, 0, 0, faultNone, 0);
    addRow(memLoad, Byte, 32'h105, 0, 0, 0, 0, faultNone, 0);
    addRow(memLoad, Word, 32'h104, 0, 0, 0, 0, faultNone, 0);
    // misaligned, memory untouched
    addRow(memLoad, Half, 32'h101, 0, 0, 0, 0, faultLoadMisaligned, 0);
    addRow(memLoad, Word, 32'h102, 0, 0, 0, 0, faultLoadMisaligned, 0);
    addRow(memStore, Half, 32'h103, 32'h0000_DEAD, 0, 0, 0, faultStoreMisaligned, 0);
    addRow(memStore, Word, 32'h106, 32'hBADC_0DE5, 0, 0, 0, faultStoreMisaligned, 0);
    addRow(memLoad, Word, 32'h104, 0, 0, 0, 0, faultNone, 0);
    // megapage mapping, one walk per page until a flush
    addRow(memStore, Word, 32'h0040_0200, 32'h1357_9BDF, 1, 0, 0, faultNone, 1);
    addRow(memLoad, Word, 32'h0040_0200, 0, 1, 0, 0, faultNone, 0);
    addRow(memLoad, Word, 32'h00C0_0200, 0, 0, 0, 0, faultNone, 0);
    addRow(memLoad, HalfU, 32'h0040_0202, 0, 1, 1, 0, faultNone, 1);
    // page faults from the walker and from the tlb
    addRow(memLoad, Word, 32'h00C0_0010, 0, 1, 0, 0, faultLoadPage, 1);
    addRow(memStore, Word, 32'h0100_0000, 32'h1111_2222, 1, 0, 0, faultStorePage, 1);
    addRow(memStore, Word, 32'h0080_0300, 32'h3333_4444, 1, 0, 0, faultStorePage, 1);
    addRow(memLoad, Word, 32'h0080_0300, 0, 1, 0, 0, faultNone, 1);
    addRow(memStore, Byte, 32'h0080_0301, 32'h0000_0055, 1, 0, 0, faultStorePage, 0);
    addRow(memLoad, Word, 32'h0080_0300, 0, 1, 0, 0, faultNone, 0);
    // lr/sc, sc result 0 means success
    addRow(memStoreCond, Word, 32'h108, 32'hAAAA_0001, 0, 0, 1, faultNone, 0);
    addRow(memLoadRes, Word, 32'h108, 0, 0, 0, 0, faultNone, 0);
    addRow(memStoreCond, Word, 32'h108, 32'hAAAA_0002, 0, 0, 0, faultNone, 0);
    addRow(memLoad, Word, 32'h108, 0, 0, 0, 0, faultNone, 0);
    addRow(memStoreCond, Word, 32'h108, 32'hAAAA_0003, 0, 0, 1, faultNone, 0);
    addRow(memLoadRes, Word, 32'h108, 0, 0, 0, 0, faultNone, 0);
    addRow(memStore, Byte, 32'h10A, 32'h0000_0055, 0, 0, 0, faultNone, 0);
    addRow(memStoreCond, Word, 32'h108, 32'hAAAA_0004, 0, 0, 1, faultNone, 0);
    addRow(memLoad, Word, 32'h108, 0, 0, 0, 0, faultNone, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // one request and its response
  ////////////////////////////////////////////////////////////

  task automatic applyRow(input int i);
    rowT r;
    pAdrT pa;
    wordT expData;
    int n;
    int hold;
    int walksBefore;
    r = rows[i];
    pa = physAdr(r.adr, r.trans);
    transEn = r.trans;
    if (r.flush) begin
      tlbFlush = 1'b1;
      @(posedge clk);
      #1;
      tlbFlush = 1'b0;
    end
    n = 0;
    while (!reqReady && n < WaitLimit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!reqReady) begin
      $display("timeout: reqReady stayed low before row %0d", i);
      timedOut = 1'b1;
      return;
    end
    walksBefore = ptReads;
    reqValid = 1'b1;
    reqOp = r.op;
    reqFunct3 = r.funct3;
    reqAdr = r.adr;
    reqWdata = r.wdata;
    @(posedge clk);
    #1;
    reqValid = 1'b0;
    n = 0;
    while (!respValid && n < WaitLimit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!respValid) begin
      $display("timeout: no response for row %0d", i);
      timedOut = 1'b1;
      return;
    end
    // respReady back-pressure, response must stay up
    hold = {$random(seed)} % 3;
    repeat (hold) begin
      @(posedge clk);
      #1;
      checks++;
      assert (respValid) else begin
        errors++;
        $display("response of row %0d was withdrawn before respReady", i);
      end
    end
    if (r.expFault == faultNone && (r.op == memLoad || r.op == memLoadRes))
      expData = loadModel(shadow[memIndex(pa)], r.funct3, r.adr[1:0]);
    else
      expData = r.expData;
    checks += 2;
    assert (respData === expData && respFault === r.expFault) else begin
      errors++;
      $display("error %0t: row %0d returned %h fault %0d, expected %h fault %0d",
               $time, i, respData, respFault, expData, r.expFault);
    end
    assert (ptReads - walksBefore == r.walks) else begin
      errors++;
      $display("error %0t: row %0d made %0d page-table reads, expected %0d",
               $time, i, ptReads - walksBefore, r.walks);
    end
    respReady = 1'b1;
    @(posedge clk);
    #1;
    respReady = 1'b0;
    checks++;
    assert (!respValid) else begin
      errors++;
      $display("response of row %0d was repeated after it was accepted", i);
    end
    // committed writes update the shadow
    if (r.expFault == faultNone &&
        (r.op == memStore || (r.op == memStoreCond && r.expData == 0)))
      shadow[memIndex(pa)] = storeModel(shadow[memIndex(pa)], r.wdata, r.funct3, r.adr[1:0]);
  endtask

  initial begin
    seed = 48;
    errors = 0;
    checks = 0;
    rowCount = 0;
    timedOut = 1'b0;
    reset = 1'b1;
    reqValid = 1'b0;
    reqOp = memNone;
    reqFunct3 = '0;
    reqAdr = '0;
    reqWdata = '0;
    respReady = 1'b0;
    transEn = 1'b0;
    ptBase = PtBase;
    tlbFlush = 1'b0;
    fillMemory();
    buildTable();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < rowCount && !timedOut; i++) begin
      applyRow(i);
    end
    $display("lsuTb: %0d rows, %0d checks, %0d errors, %0d timeouts",
             rowCount, checks, errors, timedOut);
    if (errors == 0 && !timedOut) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/lsuPkg.sv
design/walkMemIf.sv
design/dataTlb.sv
design/pageWalker.sv
design/reservationSet.sv
design/subwordUnit.sv
design/lsu.sv
sim/tbClock.sv
sim/tbMemory.sv
sim/lsuTb.sv

/* Bender.yml */
package:
  name: lsu

export_include_dirs:
  - design

sources:
  - files:
      - design/lsuPkg.sv
      - design/walkMemIf.sv
      - design/dataTlb.sv
      - design/pageWalker.sv
      - design/reservationSet.sv
      - design/subwordUnit.sv
      - design/lsu.sv
  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/tbMemory.sv
      - sim/lsuTb.sv
